// ==== include/archie_settings.svh ====
//====================
// Archimedes clock and memory settings
// System rate, erase depth and ROM download constants
//====================

`ifndef ARCHIE_SETTINGS_SVH
`define ARCHIE_SETTINGS_SVH

//====================
// Clocking
//====================

// System rate in Hz, the modulus of both rate accumulators
`define ARCHIE_CLK_SYS_HZ 32'd42_000_000

//====================
// ROM download
//====================

// Word-address bits covered by the erase sweep
`define ARCHIE_ERASE_BITS 20

// Download index that carries the ROM image
`define ARCHIE_ROM_INDEX 8'd1

// Address bits placed above the download word address
`define ARCHIE_ROM_PREFIX 2'b01

`endif

// ==== source/archie_video_pkg.sv ====
//====================
// Archimedes video types
// Mode number, base clock select and rate step
//====================

package archie_video_pkg;

	//====================
	// Video mode
	//====================

	// Upper two bits pick the base clock, lower two the pixel rate
	typedef logic [3:0] video_mode_t;

	// Base clock select on its own, also indexes the audio rates
	typedef logic [1:0] base_clk_sel_t;

	//====================
	// Rates
	//====================

	// Rate in Hz, added to an accumulator every cycle
	typedef logic [31:0] rate_step_t;

endpackage

// ==== source/archie_mem_pkg.sv ====
//====================
// Archimedes memory types
// RAM bus request and ROM download port
//====================

package archie_mem_pkg;

	//====================
	// RAM bus
	//====================

	typedef logic [31:0] word_data_t;
	typedef logic [3:0]  byte_sel_t;
	// Word address, byte lane given by byte_sel_t
	typedef logic [23:0] ram_addr_t;

	// Wishbone classic request, held until ack
	typedef struct packed {
		ram_addr_t  addr;
		word_data_t wdata;
		byte_sel_t  sel;
		logic       we;
		logic       cyc;
		logic       stb;
	} ram_req_t;

	//====================
	// Download port
	//====================

	typedef logic [15:0] dl_data_t;
	// Byte address of the current 16-bit word
	typedef logic [24:0] dl_addr_t;
	typedef logic [7:0]  dl_index_t;

	typedef struct packed {
		dl_index_t index;
		logic      active;
		logic      wr;
		dl_addr_t  addr;
		dl_data_t  data;
	} dl_port_t;

endpackage

// ==== source/rate_accumulator.sv ====
//====================
// Rate accumulator
// Turns a rate in Hz into clock enable pulses
// against the fixed system rate
//====================

`timescale 1ns/10ps

`include "archie_settings.svh"

module rate_accumulator
	import archie_video_pkg::*;
(
	input  logic       CLK_VIDEO,
	input  logic       reset,
	input  rate_step_t step_i,
	output logic       ce_o
);

	rate_step_t sum_q;
	rate_step_t sum_next;

	// Sum stays below the modulus, so the add cannot overflow
	assign sum_next = sum_q + step_i;

	always_ff @(posedge CLK_VIDEO) begin
		if (reset) begin
			sum_q <= '0;
			ce_o  <= 1'b0;
		end else if (sum_next >= `ARCHIE_CLK_SYS_HZ) begin
			// Wrap, one enable per modulus crossed
			sum_q <= sum_next - `ARCHIE_CLK_SYS_HZ;
			ce_o  <= 1'b1;
		end else begin
			sum_q <= sum_next;
			ce_o  <= 1'b0;
		end
	end

endmodule

// ==== source/video_mode_rates.sv ====
//====================
// Video mode rates
// Pixel and audio rate lookup with a mode change flag
//====================

`timescale 1ns/10ps

module video_mode_rates
	import archie_video_pkg::*;
(
	input  logic        CLK_VIDEO,
	input  logic        reset,
	input  video_mode_t mode_i,
	input  logic        aud_fix_i,
	output rate_step_t  pix_step_o,
	output rate_step_t  aud_step_o,
	output logic        mode_toggle_o
);

	//====================
	// Rate tables
	//====================

	// Row per base clock, columns are the four pixel rates
	localparam rate_step_t PIX_RATE [16] = '{
		32'd8_000_000,  32'd12_000_000, 32'd16_000_000, 32'd24_000_000,
		32'd8_391_666,  32'd12_587_500, 32'd16_783_333, 32'd25_175_000,
		32'd12_000_000, 32'd18_000_000, 32'd24_000_000, 32'd36_000_000,
		32'd8_000_000,  32'd12_000_000, 32'd16_000_000, 32'd24_000_000
	};

	localparam rate_step_t AUD_RATE [4] = '{
		32'd1_000_000, 32'd1_048_958, 32'd1_500_000, 32'd1_000_000
	};

	localparam rate_step_t AUD_FIXED = 32'd1_000_000;

	base_clk_sel_t base_clk;
	rate_step_t    pix_step_q;
	rate_step_t    aud_step_q;
	video_mode_t   mode_q;

	assign base_clk = mode_i[3:2];

	//====================
	// Step registers
	//====================

	always_ff @(posedge CLK_VIDEO) begin
		if (reset) begin
			pix_step_q <= PIX_RATE[0];
			pix_step_o <= PIX_RATE[0];
			aud_step_q <= AUD_RATE[0];
			aud_step_o <= AUD_RATE[0];
		end else begin
			pix_step_q <= PIX_RATE[mode_i];
			pix_step_o <= pix_step_q;
			// The 25 MHz family can be pinned to a plain 1 MHz audio rate
			if (aud_fix_i && base_clk == 2'd1)
				aud_step_q <= AUD_FIXED;
			else
				aud_step_q <= AUD_RATE[base_clk];
			aud_step_o <= aud_step_q;
		end
	end

	// Toggle on every mode change, the scaler resyncs on either edge
	always_ff @(posedge CLK_VIDEO) begin
		if (reset) begin
			mode_q        <= mode_i;
			mode_toggle_o <= 1'b0;
		end else begin
			mode_q <= mode_i;
			if (mode_q != mode_i)
				mode_toggle_o <= ~mode_toggle_o;
		end
	end

endmodule

// ==== source/rom_download_port.sv ====
//====================
// ROM download port
// Erases RAM, writes download words and muxes
// the loader against the core on the RAM bus
//====================

`timescale 1ns/10ps

`include "archie_settings.svh"

module rom_download_port
	import archie_mem_pkg::*;
#(
	parameter int ERASE_BITS = `ARCHIE_ERASE_BITS
) (
	input  logic     CLK_VIDEO,
	input  logic     reset,
	input  dl_port_t dl_i,
	output logic     dl_wait_o,
	input  ram_req_t core_req_i,
	output logic     core_ack_o,
	output ram_req_t ram_req_o,
	input  logic     ram_ack_i,
	input  logic     ram_ready_i,
	output logic     core_reset_o
);

	logic rom_dl;
	logic dl_old;
	logic dl_start;
	logic dl_write;
	logic erasing;
	logic wr_pend;
	logic wr_done;
	// Power-up only, survives reset
	logic boot_seen = 1'b0;

	logic [ERASE_BITS-1:0] erase_addr;
	ram_addr_t  wr_addr;
	word_data_t wr_data;
	byte_sel_t  wr_sel;
	ram_req_t   loader_req;

	assign rom_dl   = dl_i.active && (dl_i.index == `ARCHIE_ROM_INDEX);
	assign dl_start = rom_dl && !dl_old;
	assign dl_write = rom_dl && dl_i.wr && !erasing && !wr_pend;
	assign wr_done  = wr_pend && ram_ack_i;

	//====================
	// Erase and write sequencing
	//====================

	always_ff @(posedge CLK_VIDEO) begin
		if (reset) begin
			dl_old     <= 1'b0;
			erasing    <= 1'b0;
			erase_addr <= '0;
			wr_pend    <= 1'b0;
		end else begin
			dl_old <= rom_dl;
			if (wr_done)
				wr_pend <= 1'b0;
			if (!rom_dl) begin
				// Download gone, drop whatever was in flight
				erasing <= 1'b0;
				wr_pend <= 1'b0;
			end else if (dl_start) begin
				erasing    <= 1'b1;
				erase_addr <= '0;
			end else if (erasing) begin
				if (wr_done) begin
					if (&erase_addr)
						erasing <= 1'b0;
					else
						erase_addr <= erase_addr + 1'b1;
				end else if (!wr_pend) begin
					wr_pend <= 1'b1;
				end
			end else if (dl_write) begin
				wr_pend <= 1'b1;
			end
		end
	end

	// Capture the word so the host may move on once the strobe is taken
	always_ff @(posedge CLK_VIDEO) begin
		if (dl_write) begin
			wr_addr <= ram_addr_t'({`ARCHIE_ROM_PREFIX, dl_i.addr[21:2]});
			wr_data <= {dl_i.data, dl_i.data};
			wr_sel  <= dl_i.addr[1] ? 4'b1100 : 4'b0011;
		end
	end

	always_ff @(posedge CLK_VIDEO) begin
		if (rom_dl)
			boot_seen <= 1'b1;
	end

	//====================
	// RAM bus mux
	//====================

	always_comb begin
		loader_req.addr  = erasing ? ram_addr_t'(erase_addr) : wr_addr;
		loader_req.wdata = erasing ? '0 : wr_data;
		loader_req.sel   = erasing ? 4'b1111 : wr_sel;
		loader_req.we    = 1'b1;
		loader_req.cyc   = wr_pend;
		loader_req.stb   = wr_pend;
	end

	assign ram_req_o  = rom_dl ? loader_req : core_req_i;
	assign core_ack_o = rom_dl ? 1'b0 : ram_ack_i;

	// Host stalls through the erase and while a write waits for ack
	assign dl_wait_o = erasing | wr_pend;

	assign core_reset_o = reset | ~ram_ready_i | rom_dl | ~boot_seen;

endmodule

// ==== source/archie_clock_mem_top.sv ====
//====================
// Archimedes clock and memory front end
// Pixel and audio enables plus ROM download into RAM
//====================

`timescale 1ns/10ps

`include "archie_settings.svh"

module archie_clock_mem_top
	import archie_video_pkg::*;
	import archie_mem_pkg::*;
#(
	parameter int ERASE_BITS = `ARCHIE_ERASE_BITS
) (
	input  logic        CLK_VIDEO,
	input  logic        reset,
	// Video mode and enables
	input  video_mode_t mode_i,
	input  logic        aud_fix_i,
	output logic        ce_pix_o,
	output logic        ce_aud_o,
	output logic        mode_toggle_o,
	// Download from the host
	input  dl_port_t    dl_i,
	output logic        dl_wait_o,
	// Core side of the RAM bus
	input  ram_req_t    core_req_i,
	output logic        core_ack_o,
	output word_data_t  core_rdata_o,
	// RAM side
	output ram_req_t    ram_req_o,
	input  logic        ram_ack_i,
	input  word_data_t  ram_rdata_i,
	input  logic        ram_ready_i,
	output logic        core_reset_o
);

	rate_step_t pix_step;
	rate_step_t aud_step;

	//====================
	// Clock enables
	//====================

	video_mode_rates rates (
		.CLK_VIDEO     (CLK_VIDEO),
		.reset         (reset),
		.mode_i        (mode_i),
		.aud_fix_i     (aud_fix_i),
		.pix_step_o    (pix_step),
		.aud_step_o    (aud_step),
		.mode_toggle_o (mode_toggle_o)
	);

	rate_accumulator pix_ce (
		.CLK_VIDEO (CLK_VIDEO),
		.reset     (reset),
		.step_i    (pix_step),
		.ce_o      (ce_pix_o)
	);

	rate_accumulator aud_ce (
		.CLK_VIDEO (CLK_VIDEO),
		.reset     (reset),
		.step_i    (aud_step),
		.ce_o      (ce_aud_o)
	);

	//====================
	// Memory front end
	//====================

	rom_download_port #(
		.ERASE_BITS (ERASE_BITS)
	) dl_port (
		.CLK_VIDEO    (CLK_VIDEO),
		.reset        (reset),
		.dl_i         (dl_i),
		.dl_wait_o    (dl_wait_o),
		.core_req_i   (core_req_i),
		.core_ack_o   (core_ack_o),
		.ram_req_o    (ram_req_o),
		.ram_ack_i    (ram_ack_i),
		.ram_ready_i  (ram_ready_i),
		.core_reset_o (core_reset_o)
	);

	// Read data is only sampled by the core on its own ack
	assign core_rdata_o = ram_rdata_i;

endmodule

// ==== tests/tb_archie_clock_mem.sv ====
//====================
// Testbench for the Archimedes clock and memory front end
// Rate table, ROM download with erase, core passthrough
//====================

`timescale 1ns/10ps

`include "archie_settings.svh"

module tb_archie_clock_mem
	import archie_video_pkg::*;
	import archie_mem_pkg::*;
();

	typedef struct packed {
		video_mode_t mode;
		logic        aud_fix;
		rate_step_t  pix_step;
		rate_step_t  aud_step;
	} rate_row_t;

	localparam int ROWS      = 10;
	localparam int WINDOW    = 4200;
	localparam int RAM_WORDS = 512;

	logic        CLK_VIDEO;
	logic        reset;
	video_mode_t mode_i;
	logic        aud_fix_i;
	logic        ce_pix_o;
	logic        ce_aud_o;
	logic        mode_toggle_o;
	dl_port_t    dl_i;
	logic        dl_wait_o;
	ram_req_t    core_req_i;
	logic        core_ack_o;
	word_data_t  core_rdata_o;
	ram_req_t    ram_req_o;
	logic        ram_ack_i;
	word_data_t  ram_rdata_i;
	logic        ram_ready_i;
	logic        core_reset_o;

	rate_row_t  rate_table [ROWS];
	word_data_t ram_mem [RAM_WORDS];
	word_data_t merged;
	logic [1:0] ack_delay;
	logic [31:0] rnd;
	integer     seed = 32'h12d5_3af5;
	int         errors = 0;
	int         checks = 0;

	archie_clock_mem_top #(
		.ERASE_BITS (6)
	) DUT (
		.CLK_VIDEO     (CLK_VIDEO),
		.reset         (reset),
		.mode_i        (mode_i),
		.aud_fix_i     (aud_fix_i),
		.ce_pix_o      (ce_pix_o),
		.ce_aud_o      (ce_aud_o),
		.mode_toggle_o (mode_toggle_o),
		.dl_i          (dl_i),
		.dl_wait_o     (dl_wait_o),
		.core_req_i    (core_req_i),
		.core_ack_o    (core_ack_o),
		.core_rdata_o  (core_rdata_o),
		.ram_req_o     (ram_req_o),
		.ram_ack_i     (ram_ack_i),
		.ram_rdata_i   (ram_rdata_i),
		.ram_ready_i   (ram_ready_i),
		.core_reset_o  (core_reset_o)
	);

	always #50 CLK_VIDEO = ~CLK_VIDEO;

	//====================
	// RAM model
	//====================

	// Low window and ROM window fold into one small array
	function automatic int ram_index(input ram_addr_t addr);
		return {addr[20], addr[7:0]};
	endfunction

	// Ack after 0 to 3 wait cycles and for one cycle per transfer
	always @(posedge CLK_VIDEO) begin
		ram_ack_i <= 1'b0;
		if (reset) begin
			ack_delay <= 2'd0;
		end else if (ram_req_o.cyc && ram_req_o.stb && !ram_ack_i) begin
			if (ack_delay != 2'd0) begin
				ack_delay <= ack_delay - 2'd1;
			end else begin
				merged = ram_mem[ram_index(ram_req_o.addr)];
				for (int b = 0; b < 4; b++)
					if (ram_req_o.sel[b])
						merged[8*b +: 8] = ram_req_o.wdata[8*b +: 8];
				if (ram_req_o.we)
					ram_mem[ram_index(ram_req_o.addr)] <= merged;
				ram_rdata_i <= ram_mem[ram_index(ram_req_o.addr)];
				ram_ack_i   <= 1'b1;
				rnd = $random(seed);
				ack_delay <= rnd[1:0];
			end
		end
	end

	//====================
	// Helpers
	//====================

	task automatic check_value(input longint actual, input longint expected, input int tol,
		input string what);
		longint diff;
		diff = actual - expected;
		if (diff < 0)
			diff = -diff;
		checks++;
		if (diff > tol) begin
			errors++;
			$display("error at %0t ns: %s, got %0d, expected %0d", $time, what, actual,
				expected);
		end
	endtask

	function automatic ram_req_t core_request(input ram_addr_t addr, input word_data_t wdata,
		input byte_sel_t sel, input logic we);
		ram_req_t req;
		req.addr  = addr;
		req.wdata = wdata;
		req.sel   = sel;
		req.we    = we;
		req.cyc   = 1'b1;
		req.stb   = 1'b1;
		return req;
	endfunction

	// The core stays held and unserved while the download runs
	task automatic wait_dl_wait(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (dl_wait_o !== level && n < limit) begin
			@(posedge CLK_VIDEO);
			n++;
			check_value(core_reset_o, 1, 0, "core_reset_o during download");
			check_value(core_ack_o, 0, 0, "core_ack_o during download");
		end
		if (dl_wait_o !== level) begin
			errors++;
			$display("timeout waiting for %s", what);
		end
	endtask

	task automatic core_transfer(input ram_req_t req, output word_data_t rdata);
		int n;
		int acks;
		n = 0;
		acks = 0;
		rdata = '0;
		core_req_i <= req;
		while (acks == 0 && n < 50) begin
			@(posedge CLK_VIDEO);
			n++;
			if (core_ack_o) begin
				acks++;
				rdata = core_rdata_o;
			end
		end
		core_req_i <= '0;
		if (acks == 0) begin
			errors++;
			$display("timeout waiting for core_ack_o on a core request");
		end
		// Idle bus afterwards must not ack again
		repeat (4) begin
			@(posedge CLK_VIDEO);
			if (core_ack_o)
				acks++;
		end
		check_value(acks, 1, 0, "core_ack_o pulses per request");
	endtask

	//====================
	// Rate table
	//====================

	task automatic load_rate_table();
		rate_table[0] = '{4'd0,  1'b0, 32'd8_000_000,  32'd1_000_000};
		rate_table[1] = '{4'd3,  1'b0, 32'd24_000_000, 32'd1_000_000};
		rate_table[2] = '{4'd3,  1'b0, 32'd24_000_000, 32'd1_000_000};
		rate_table[3] = '{4'd5,  1'b0, 32'd12_587_500, 32'd1_048_958};
		rate_table[4] = '{4'd7,  1'b1, 32'd25_175_000, 32'd1_000_000};
		rate_table[5] = '{4'd7,  1'b0, 32'd25_175_000, 32'd1_048_958};
		rate_table[6] = '{4'd10, 1'b0, 32'd24_000_000, 32'd1_500_000};
		rate_table[7] = '{4'd11, 1'b1, 32'd36_000_000, 32'd1_500_000};
		rate_table[8] = '{4'd14, 1'b1, 32'd16_000_000, 32'd1_000_000};
		rate_table[9] = '{4'd4,  1'b0, 32'd8_391_666,  32'd1_048_958};
	endtask

	task automatic sweep_rate_table();
		video_mode_t prev_mode;
		logic        last_toggle;
		int          pix_count;
		int          aud_count;
		int          toggles;
		longint      pix_exp;
		longint      aud_exp;
		prev_mode = 4'd0;
		for (int r = 0; r < ROWS; r++) begin
			mode_i    <= rate_table[r].mode;
			aud_fix_i <= rate_table[r].aud_fix;
			pix_count = 0;
			aud_count = 0;
			toggles = 0;
			last_toggle = mode_toggle_o;
			// First 4 cycles let the new steps settle
			for (int c = 0; c < 4 + WINDOW; c++) begin
				@(posedge CLK_VIDEO);
				if (mode_toggle_o !== last_toggle)
					toggles++;
				last_toggle = mode_toggle_o;
				if (c >= 4) begin
					pix_count += ce_pix_o;
					aud_count += ce_aud_o;
				end
			end
			pix_exp = longint'(rate_table[r].pix_step) * WINDOW / `ARCHIE_CLK_SYS_HZ;
			aud_exp = longint'(rate_table[r].aud_step) * WINDOW / `ARCHIE_CLK_SYS_HZ;
			check_value(pix_count, pix_exp, 1, $sformatf("pixel pulses in row %0d", r));
			check_value(aud_count, aud_exp, 1, $sformatf("audio pulses in row %0d", r));
			check_value(toggles, (rate_table[r].mode != prev_mode) ? 1 : 0, 0,
				$sformatf("mode toggles in row %0d", r));
			prev_mode = rate_table[r].mode;
		end
	endtask

	//====================
	// ROM download
	//====================

	task automatic download_rom();
		dl_addr_t   byte_addr;
		dl_data_t   word;
		ram_addr_t  waddr;
		word_data_t beyond_erase;
		word_data_t expected [4];
		beyond_erase = ram_mem[64];
		core_req_i  <= core_request(24'd5, 32'hdead_beef, 4'hf, 1'b1);
		dl_i.index  <= `ARCHIE_ROM_INDEX;
		dl_i.active <= 1'b1;
		@(posedge CLK_VIDEO);
		wait_dl_wait(1'b1, 8, "dl_wait_o to rise at the start of the erase");
		wait_dl_wait(1'b0, 2000, "the erase sweep to finish");
		for (int i = 0; i < 64; i++)
			check_value(ram_mem[i], 0, 0, $sformatf("erased word %0d", i));
		check_value(ram_mem[64], beyond_erase, 0, "word past the erase region");
		// Consecutive 16-bit words fill both halves of each RAM word
		for (int k = 0; k < 8; k++) begin
			byte_addr = dl_addr_t'(2 * k);
			word = 16'ha55a ^ dl_data_t'(k * 16'h1357);
			if (byte_addr[1])
				expected[k / 2][31:16] = word;
			else
				expected[k / 2][15:0] = word;
			dl_i.addr <= byte_addr;
			dl_i.data <= word;
			dl_i.wr   <= 1'b1;
			@(posedge CLK_VIDEO);
			dl_i.wr <= 1'b0;
			@(posedge CLK_VIDEO);
			wait_dl_wait(1'b0, 100, "a download write to be acked");
		end
		for (int w = 0; w < 4; w++) begin
			byte_addr = dl_addr_t'(4 * w);
			// Prefix sits above the 20 word-address bits taken from the byte address
			waddr = (ram_addr_t'(`ARCHIE_ROM_PREFIX) << 20) + ram_addr_t'(byte_addr / 4);
			check_value(ram_mem[ram_index(waddr)], expected[w], 0,
				$sformatf("downloaded word %0d", w));
		end
		core_req_i  <= '0;
		dl_i.active <= 1'b0;
		dl_i.index  <= '0;
	endtask

	//====================
	// Core access
	//====================

	task automatic access_core();
		word_data_t rdata;
		int         n;
		n = 0;
		while (core_reset_o !== 1'b0 && n < 16) begin
			@(posedge CLK_VIDEO);
			n++;
		end
		if (core_reset_o !== 1'b0) begin
			errors++;
			$display("timeout waiting for core_reset_o to fall after the download");
		end
		core_transfer(core_request(24'd48, 32'h5a0f_c3e1, 4'hf, 1'b1), rdata);
		core_transfer(core_request(24'd48, 32'h0, 4'hf, 1'b0), rdata);
		check_value(rdata, 32'h5a0f_c3e1, 0, "core read data");
		// RAM not ready holds the core in reset again
		ram_ready_i <= 1'b0;
		@(posedge CLK_VIDEO);
		check_value(core_reset_o, 1, 0, "core_reset_o while the RAM is not ready");
		ram_ready_i <= 1'b1;
		@(posedge CLK_VIDEO);
		check_value(core_reset_o, 0, 0, "core_reset_o once the RAM is ready again");
	endtask

	//====================
	// Main sequence
	//====================

	initial begin
		CLK_VIDEO   = 1'b0;
		reset       = 1'b1;
		mode_i      = 4'd0;
		aud_fix_i   = 1'b0;
		dl_i        = '0;
		core_req_i  = '0;
		ram_ack_i   = 1'b0;
		ram_rdata_i = '0;
		ram_ready_i = 1'b0;
		load_rate_table();
		for (int i = 0; i < RAM_WORDS; i++)
			ram_mem[i] = $random(seed);
		repeat (10) @(posedge CLK_VIDEO);
		reset       <= 1'b0;
		ram_ready_i <= 1'b1;
		@(posedge CLK_VIDEO);
		check_value(ram_req_o.cyc, 0, 0, "ram cyc after reset");
		check_value(ram_req_o.stb, 0, 0, "ram stb after reset");
		check_value(dl_wait_o, 0, 0, "dl_wait_o after reset");
		check_value(mode_toggle_o, 0, 0, "mode_toggle_o after reset");
		check_value(core_reset_o, 1, 0, "core_reset_o before the first download");
		sweep_rate_table();
		download_rom();
		access_core();
		$display("closing report: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+include
source/archie_video_pkg.sv
source/archie_mem_pkg.sv
source/rate_accumulator.sv
source/video_mode_rates.sv
source/rom_download_port.sv
source/archie_clock_mem_top.sv
tests/tb_archie_clock_mem.sv

// ==== Bender.yml ====
package:
  name: archie_clock_mem

export_include_dirs:
  - include

sources:
  # Packages first, then the RTL bottom up
  - source/archie_video_pkg.sv
  - source/archie_mem_pkg.sv
  - source/rate_accumulator.sv
  - source/video_mode_rates.sv
  - source/rom_download_port.sv
  - source/archie_clock_mem_top.sv
  - target: test
    files:
      - tests/tb_archie_clock_mem.sv
